/* files.f */
+incdir+include
src/fetch_state_pkg.sv
src/pc_ctrl_pkg.sv
src/fetch_cfg_regs.sv
src/pc_gen.sv
src/fetch_stage.sv
src/fetch_top.sv
verif/tb_rom_model.sv
verif/tb_fetch_top.sv

/* verif/tb_fetch_top.sv */
`default_nettype none

`include "fetch_config.svh"

module tb_fetch_top;
    timeunit 1ns;
    timeprecision 100ps;

    logic                  clk;
    logic                  rst_n;
    logic                  cfg_we;
    pc_ctrl_pkg::cfg_reg_e cfg_addr;
    logic [`BUS_WIDTH-1:0] cfg_wdata;
    logic                  hold;
    logic                  flush;
    logic [`BUS_WIDTH-1:0] redirect_pc;
    logic                  trap;
    logic                  allow_in_id;

    wire                   mem_data_ok;
    wire [`DATA_WIDTH-1:0] rom_rdata;
    wire                   rom_req;
    wire [`BUS_WIDTH-1:0]  rom_addr;
    wire [`BUS_WIDTH-1:0]  pc_if;
    wire [`DATA_WIDTH-1:0] instruction_if;
    wire                   valid_if;
    wire                   ready_go_if;
    wire                   handoff = valid_if & ready_go_if & allow_in_id;

    // scoreboard, next pc decode should see
    logic [`BUS_WIDTH-1:0]  exp_pc;
    // address the next memory read should carry
    logic [`BUS_WIDTH-1:0]  exp_addr;
    logic [`BUS_WIDTH-1:0]  exp_trap_vec;
    logic                   exp_fetch_en;
    logic                   outstanding;
    // item offered last edge and not taken
    logic                   stalled;
    // item already had its word last edge
    logic                   word_held;
    logic [`BUS_WIDTH-1:0]  prev_pc;
    logic [`DATA_WIDTH-1:0] prev_inst;
    integer                 handoff_count = 0;
    integer                 seed;
    integer                 i;

    fetch_top i_fetch_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg_we         (cfg_we),
        .cfg_addr       (cfg_addr),
        .cfg_wdata      (cfg_wdata),
        .hold           (hold),
        .flush          (flush),
        .redirect_pc    (redirect_pc),
        .trap           (trap),
        .allow_in_id    (allow_in_id),
        .mem_data_ok    (mem_data_ok),
        .rom_rdata      (rom_rdata),
        .rom_req        (rom_req),
        .rom_addr       (rom_addr),
        .pc_if          (pc_if),
        .instruction_if (instruction_if),
        .valid_if       (valid_if),
        .ready_go_if    (ready_go_if)
    );

    tb_rom_model i_rom_model (
        .clk         (clk),
        .rst_n       (rst_n),
        .rom_req     (rom_req),
        .rom_addr    (rom_addr),
        .mem_data_ok (mem_data_ok),
        .rom_rdata   (rom_rdata)
    );

    always #2 clk = ~clk;

    //////////////////////////////
    // reference model
    //////////////////////////////

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_pc       <= `RESET_PC;
            exp_addr     <= `RESET_PC;
            exp_trap_vec <= `RESET_TRAP_VEC;
            exp_fetch_en <= 1'b1;
            outstanding  <= 1'b0;
            stalled      <= 1'b0;
            word_held    <= 1'b0;
        end else begin
            // flush picks the new stream, else step by one word
            if (flush) begin
                exp_pc <= trap ? exp_trap_vec : redirect_pc;
            end else if (handoff) begin
                exp_pc <= exp_pc + 32'd4;
            end
            if (flush) begin
                exp_addr <= trap ? exp_trap_vec : redirect_pc;
            end else if (rom_req) begin
                exp_addr <= exp_addr + 32'd4;
            end
            if (cfg_we && cfg_addr == pc_ctrl_pkg::cfg_trap_vec) begin
                exp_trap_vec <= cfg_wdata & 32'hFFFF_FFFC;
            end
            if (cfg_we && cfg_addr == pc_ctrl_pkg::cfg_ctrl) begin
                exp_fetch_en <= cfg_wdata[`CFG_CTRL_EN_BIT];
            end
            outstanding <= rom_req | (outstanding & ~mem_data_ok);
            stalled     <= valid_if & ~handoff;
            word_held   <= valid_if & ~handoff & (word_held | mem_data_ok);
            prev_pc     <= pc_if;
            prev_inst   <= instruction_if;
        end
    end

    always @(posedge clk) begin
        handoff_count <= handoff_count + handoff;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    //////////////////////////////
    // checks
    //////////////////////////////

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !valid_if)
        else abort_run($sformatf("CHECK FAILED valid_if got %h expected %h",
                                 $sampled(valid_if), 1'b0));
    a_reset_no_req: assert property (@(posedge clk) !rst_n |-> !rom_req)
        else abort_run($sformatf("CHECK FAILED rom_req got %h expected %h",
                                 $sampled(rom_req), 1'b0));
    a_req_addr: assert property (@(posedge clk) disable iff (!rst_n)
                                 rom_req |-> rom_addr == exp_addr)
        else abort_run($sformatf("CHECK FAILED rom_addr got %h expected %h",
                                 $sampled(rom_addr), $sampled(exp_addr)));
    a_pc_order: assert property (@(posedge clk) disable iff (!rst_n)
                                 handoff |-> pc_if == exp_pc)
        else abort_run($sformatf("CHECK FAILED pc_if got %h expected %h",
                                 $sampled(pc_if), $sampled(exp_pc)));
    a_inst_data: assert property (@(posedge clk) disable iff (!rst_n)
                                  handoff |-> instruction_if == (pc_if ^ 32'hA5A5_0000))
        else abort_run($sformatf("CHECK FAILED instruction_if got %h expected %h",
                                 $sampled(instruction_if), $sampled(pc_if) ^ 32'hA5A5_0000));
    a_pc_stable: assert property (@(posedge clk) disable iff (!rst_n)
                                  stalled |-> pc_if == prev_pc)
        else abort_run($sformatf("CHECK FAILED pc_if got %h expected %h",
                                 $sampled(pc_if), $sampled(prev_pc)));
    a_inst_stable: assert property (@(posedge clk) disable iff (!rst_n)
                                    word_held |-> instruction_if == prev_inst)
        else abort_run($sformatf("CHECK FAILED instruction_if got %h expected %h",
                                 $sampled(instruction_if), $sampled(prev_inst)));
    a_fetch_off: assert property (@(posedge clk) disable iff (!rst_n)
                                  !exp_fetch_en |-> !rom_req)
        else abort_run($sformatf("CHECK FAILED rom_req got %h expected %h",
                                 $sampled(rom_req), 1'b0));
    a_one_read: assert property (@(posedge clk) disable iff (!rst_n)
                                 rom_req |-> (!outstanding || mem_data_ok))
        else abort_run("new memory read issued while another read was still pending");

    //////////////////////////////
    // stimulus tasks
    //////////////////////////////

    task automatic wait_handoffs(input integer n);
        integer target;
        integer cycles;
        target = handoff_count + n;
        cycles = 0;
        while (handoff_count < target) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles > 20 * n + 20) begin
                abort_run($sformatf("timed out waiting for %0d instructions", n));
            end
        end
    endtask

    task automatic wait_read_pending();
        integer cycles;
        cycles = 0;
        while (!outstanding) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles > 50) begin
                abort_run("timed out waiting for a memory read to be issued");
            end
        end
    endtask

    task automatic wait_drained();
        integer cycles;
        cycles = 0;
        while (outstanding || valid_if) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles > 50) begin
                abort_run("timed out waiting for the fetch pipeline to drain");
            end
        end
    endtask

    task automatic cfg_write(input pc_ctrl_pkg::cfg_reg_e addr, input logic [31:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    // kill the stream while a read is out
    task automatic flush_pipe(input logic [31:0] target, input logic use_trap);
        wait_read_pending();
        flush       = 1'b1;
        trap        = use_trap;
        redirect_pc = target;
        @(negedge clk);
        flush       = 1'b0;
        trap        = 1'b0;
    endtask

    task automatic random_backpressure(input integer cycles);
        repeat (cycles) begin
            allow_in_id = (($random(seed) & 3) != 0);
            hold        = (($random(seed) & 7) == 0);
            @(negedge clk);
        end
        allow_in_id = 1'b1;
        hold        = 1'b0;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    initial begin
        seed        = 59;
        clk         = 1'b0;
        cfg_we      = 1'b0;
        cfg_addr    = pc_ctrl_pkg::cfg_boot_pc;
        cfg_wdata   = '0;
        hold        = 1'b0;
        flush       = 1'b0;
        redirect_pc = '0;
        trap        = 1'b0;
        allow_in_id = 1'b1;
        apply_reset();

        // boot stream, then decode stalls
        wait_handoffs(8);
        random_backpressure(300);
        wait_handoffs(4);

        // redirects, some land in leap
        for (i = 0; i < 6; i = i + 1) begin
            flush_pipe(32'h0000_2000 + i * 32'h100, 1'b0);
            wait_handoffs(3);
        end
        random_backpressure(150);

        // trap vector written unaligned
        cfg_write(pc_ctrl_pkg::cfg_trap_vec, 32'h0000_0403);
        flush_pipe(32'h0000_5000, 1'b1);
        wait_handoffs(4);

        // fetch off, drain, idle, back on
        cfg_write(pc_ctrl_pkg::cfg_ctrl, 32'h0);
        wait_drained();
        repeat (20) @(negedge clk);
        cfg_write(pc_ctrl_pkg::cfg_ctrl, 32'h1);
        wait_handoffs(6);

        // new boot pc is lost across reset
        cfg_write(pc_ctrl_pkg::cfg_boot_pc, 32'h0000_3000);
        apply_reset();
        wait_handoffs(4);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_rom_model.sv */
`default_nettype none

`include "fetch_config.svh"

module tb_rom_model (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    rom_req,
    input  wire [`BUS_WIDTH-1:0]   rom_addr,
    output logic                   mem_data_ok,
    output logic [`DATA_WIDTH-1:0] rom_rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    integer                lat_seed;
    // cycles left until the strobe
    integer                remaining;
    logic                  req_taken;
    logic [`BUS_WIDTH-1:0] req_addr;
    logic [`BUS_WIDTH-1:0] pend_addr;

    initial begin
        lat_seed  = 59;
        remaining = 0;
    end

    // request lands with the move into fetch
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_taken <= 1'b0;
            req_addr  <= '0;
        end else begin
            req_taken <= rom_req;
            if (rom_req) begin
                req_addr <= rom_addr;
            end
        end
    end

    // strobe and data change between edges
    // latency of 1 means sampled at the next edge
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_data_ok <= 1'b0;
            rom_rdata   <= '0;
            remaining = 0;
        end else begin
            mem_data_ok <= 1'b0;
            if (req_taken) begin
                remaining = 1 + ($unsigned($random(lat_seed)) % 8);
                pend_addr = req_addr;
            end
            if (remaining > 0) begin
                remaining = remaining - 1;
                if (remaining == 0) begin
                    mem_data_ok <= 1'b1;
                    // word derived from the address
                    rom_rdata   <= pend_addr ^ 32'hA5A5_0000;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/fetch_top.sv */
`default_nettype none

`include "fetch_config.svh"

module fetch_top (
    input  wire                          clk,
    input  wire                          rst_n,
    // config write port
    input  wire                          cfg_we,
    input  wire pc_ctrl_pkg::cfg_reg_e   cfg_addr,
    input  wire [`BUS_WIDTH-1:0]         cfg_wdata,
    // decode side control
    input  wire                          hold,
    input  wire                          flush,
    input  wire [`BUS_WIDTH-1:0]         redirect_pc,
    input  wire                          trap,
    input  wire                          allow_in_id,
    // instruction memory
    input  wire                          mem_data_ok,
    input  wire [`DATA_WIDTH-1:0]        rom_rdata,
    output logic                         rom_req,
    output logic [`BUS_WIDTH-1:0]        rom_addr,
    // to decode
    output logic [`BUS_WIDTH-1:0]        pc_if,
    output logic [`DATA_WIDTH-1:0]       instruction_if,
    output logic                         valid_if,
    output logic                         ready_go_if
);

    // config to pre-fetch
    logic [`BUS_WIDTH-1:0] boot_pc;
    logic [`BUS_WIDTH-1:0] trap_vec;
    logic                  fetch_en;

    // pre-fetch to fetch
    logic [`BUS_WIDTH-1:0] next_pc;
    logic                  valid_pre;
    logic                  ready_go_pre;
    logic                  allow_in_if;

    fetch_cfg_regs i_fetch_cfg_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .boot_pc   (boot_pc),
        .trap_vec  (trap_vec),
        .fetch_en  (fetch_en)
    );

    pc_gen i_pc_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .boot_pc      (boot_pc),
        .trap_vec     (trap_vec),
        .fetch_en     (fetch_en),
        .flush        (flush),
        .redirect_pc  (redirect_pc),
        .trap         (trap),
        .allow_in_if  (allow_in_if),
        .next_pc      (next_pc),
        .valid_pre    (valid_pre),
        .ready_go_pre (ready_go_pre),
        .rom_req      (rom_req),
        .rom_addr     (rom_addr)
    );

    fetch_stage i_fetch_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .hold           (hold),
        .flush          (flush),
        .mem_data_ok    (mem_data_ok),
        .rom_rdata      (rom_rdata),
        .next_pc        (next_pc),
        .valid_pre      (valid_pre),
        .ready_go_pre   (ready_go_pre),
        .allow_in_if    (allow_in_if),
        .allow_in_id    (allow_in_id),
        .pc_if          (pc_if),
        .instruction_if (instruction_if),
        .valid_if       (valid_if),
        .ready_go_if    (ready_go_if)
    );

endmodule

`default_nettype wire

/* src/fetch_stage.sv */
`default_nettype none

`include "fetch_config.svh"

module fetch_stage (
    input  wire                    clk,
    input  wire                    rst_n,
    // decode stall and pipeline kill
    input  wire                    hold,
    input  wire                    flush,
    // memory response
    input  wire                    mem_data_ok,
    input  wire [`DATA_WIDTH-1:0]  rom_rdata,
    // from pre-fetch
    input  wire [`BUS_WIDTH-1:0]   next_pc,
    input  wire                    valid_pre,
    input  wire                    ready_go_pre,
    output logic                   allow_in_if,
    // to decode
    input  wire                    allow_in_id,
    output logic [`BUS_WIDTH-1:0]  pc_if,
    output logic [`DATA_WIDTH-1:0] instruction_if,
    output logic                   valid_if,
    output logic                   ready_go_if
);

    fetch_state_pkg::fetch_state_e state;
    fetch_state_pkg::fetch_state_e next_state;

    logic [`BUS_WIDTH-1:0]  pc;
    logic                   valid;
    // holds the word while decode stalls
    logic [`DATA_WIDTH-1:0] inst_buf;

    logic pipe_in;
    logic waiting;
    logic buffered;
    logic handoff;
    logic capture;

    //////////////////////////////
    // pipeline handshake
    //////////////////////////////

    // item offered by pre-fetch, killed by flush
    assign pipe_in  = valid_pre & ready_go_pre & ~flush;
    assign waiting  = (state == fetch_state_pkg::state_empty) ||
                      (state == fetch_state_pkg::state_pipe);
    assign buffered = (state == fetch_state_pkg::state_full);

    // flushed item never reaches decode
    assign valid_if = valid & ~flush;

    // word in hand, either buffered or arriving now
    assign ready_go_if = ~hold & (buffered | (waiting & mem_data_ok));

    assign handoff = valid_if & ready_go_if & allow_in_id;

    // data arrived but decode did not take it
    assign capture = waiting & valid_if & mem_data_ok & ~handoff;

    // room only when no read is left in flight
    // leap frees up as the stale word lands
    always_comb begin
        if (state == fetch_state_pkg::state_leap) begin
            allow_in_if = mem_data_ok;
        end else begin
            allow_in_if = ~valid | handoff;
        end
    end

    assign pc_if          = pc;
    assign instruction_if = buffered ? inst_buf : rom_rdata;

    //////////////////////////////
    // state machine
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= fetch_state_pkg::state_empty;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            fetch_state_pkg::state_leap: begin
                // stale word is thrown away
                if (mem_data_ok) begin
                    next_state = fetch_state_pkg::state_empty;
                end
            end
            fetch_state_pkg::state_empty,
            fetch_state_pkg::state_pipe: begin
                if (flush) begin
                    // read still out, skip its answer
                    if (valid && !mem_data_ok) begin
                        next_state = fetch_state_pkg::state_leap;
                    end else begin
                        next_state = fetch_state_pkg::state_empty;
                    end
                end else if (valid && mem_data_ok) begin
                    if (handoff) begin
                        next_state = fetch_state_pkg::state_pipe;
                    end else begin
                        next_state = fetch_state_pkg::state_full;
                    end
                end else begin
                    next_state = fetch_state_pkg::state_empty;
                end
            end
            fetch_state_pkg::state_full: begin
                // buffer drains to decode or is killed
                if (flush || handoff) begin
                    next_state = fetch_state_pkg::state_empty;
                end
            end
            default: begin
                next_state = fetch_state_pkg::state_empty;
            end
        endcase
    end

    //////////////////////////////
    // item registers
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (allow_in_if) begin
            valid <= pipe_in;
        end
    end

    // pc follows the item accepted from pre-fetch
    always_ff @(posedge clk) begin
        if (allow_in_if && pipe_in) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            inst_buf <= `INST_NOP;
        end else if (capture) begin
            inst_buf <= rom_rdata;
        end
    end

endmodule

`default_nettype wire

/* src/pc_gen.sv */
`default_nettype none

`include "fetch_config.svh"

module pc_gen (
    input  wire                   clk,
    input  wire                   rst_n,
    // config
    input  wire [`BUS_WIDTH-1:0]  boot_pc,
    input  wire [`BUS_WIDTH-1:0]  trap_vec,
    input  wire                   fetch_en,
    // redirect from later stages
    input  wire                   flush,
    input  wire [`BUS_WIDTH-1:0]  redirect_pc,
    input  wire                   trap,
    // fetch stage has room
    input  wire                   allow_in_if,
    // to fetch stage
    output logic [`BUS_WIDTH-1:0] next_pc,
    output logic                  valid_pre,
    output logic                  ready_go_pre,
    // instruction memory read
    output logic                  rom_req,
    output logic [`BUS_WIDTH-1:0] rom_addr
);

    pc_ctrl_pkg::pc_sel_e  pc_sel;
    // pc of the last item handed to fetch
    logic [`BUS_WIDTH-1:0] pc_q;
    // redirect target held until taken
    logic [`BUS_WIDTH-1:0] redir_pc;
    logic                  boot_pend;
    logic                  redir_pend;
    logic                  trap_pend;
    logic                  accept;

    // nothing is offered while in reset
    assign valid_pre    = fetch_en & rst_n;
    // selection settles the cycle after a flush
    assign ready_go_pre = ~flush;
    assign accept       = valid_pre & ready_go_pre & allow_in_if;

    // read goes out with the move into fetch
    assign rom_req  = accept;
    assign rom_addr = next_pc;

    // trap beats redirect beats boot
    always_comb begin
        if (trap_pend) begin
            pc_sel = pc_ctrl_pkg::pc_sel_trap;
        end else if (redir_pend) begin
            pc_sel = pc_ctrl_pkg::pc_sel_redirect;
        end else if (boot_pend) begin
            pc_sel = pc_ctrl_pkg::pc_sel_boot;
        end else begin
            pc_sel = pc_ctrl_pkg::pc_sel_seq;
        end
    end

    always_comb begin
        case (pc_sel)
            pc_ctrl_pkg::pc_sel_redirect: next_pc = redir_pc;
            pc_ctrl_pkg::pc_sel_trap:     next_pc = trap_vec;
            pc_ctrl_pkg::pc_sel_boot:     next_pc = boot_pc;
            default:                      next_pc = pc_q + 32'd4;
        endcase
    end

    // pending sources, cleared once fetch takes the item
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            boot_pend  <= 1'b1;
            redir_pend <= 1'b0;
            trap_pend  <= 1'b0;
        end else if (flush) begin
            trap_pend  <= trap;
            redir_pend <= ~trap;
        end else if (accept) begin
            boot_pend  <= 1'b0;
            redir_pend <= 1'b0;
            trap_pend  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            redir_pc <= redirect_pc;
        end
        if (accept) begin
            pc_q <= next_pc;
        end
    end

endmodule

`default_nettype wire

/* src/fetch_cfg_regs.sv */
`default_nettype none

`include "fetch_config.svh"

module fetch_cfg_regs (
    input  wire                          clk,
    input  wire                          rst_n,
    // simple write port
    input  wire                          cfg_we,
    input  wire pc_ctrl_pkg::cfg_reg_e   cfg_addr,
    input  wire [`BUS_WIDTH-1:0]         cfg_wdata,
    // to the pre-fetch stage
    output logic [`BUS_WIDTH-1:0]        boot_pc,
    output logic [`BUS_WIDTH-1:0]        trap_vec,
    output logic                         fetch_en
);

    // pc values are always word aligned
    logic [`BUS_WIDTH-1:0] wdata_aligned;

    assign wdata_aligned = {cfg_wdata[`BUS_WIDTH-1:2], 2'b00};

    //////////////////////////////
    // register file
    //////////////////////////////

    // write lands on the next edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            boot_pc  <= `RESET_PC;
            trap_vec <= `RESET_TRAP_VEC;
            // fetch runs out of reset
            fetch_en <= 1'b1;
        end else if (cfg_we) begin
            case (cfg_addr)
                pc_ctrl_pkg::cfg_boot_pc: begin
                    boot_pc <= wdata_aligned;
                end
                pc_ctrl_pkg::cfg_trap_vec: begin
                    trap_vec <= wdata_aligned;
                end
                pc_ctrl_pkg::cfg_ctrl: begin
                    fetch_en <= cfg_wdata[`CFG_CTRL_EN_BIT];
                end
                // unmapped address, drop the write
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/pc_ctrl_pkg.sv */
`default_nettype none

`include "fetch_config.svh"

package pc_ctrl_pkg;

    // where the next fetch pc comes from
    typedef enum logic [1:0] {
        pc_sel_seq      = 2'b00,
        pc_sel_redirect = 2'b01,
        pc_sel_trap     = 2'b10,
        pc_sel_boot     = 2'b11
    } pc_sel_e;

    // config register map, top code is unused
    typedef enum logic [`CFG_ADDR_W-1:0] {
        cfg_boot_pc  = `CFG_ADDR_BOOT_PC,
        cfg_trap_vec = `CFG_ADDR_TRAP_VEC,
        cfg_ctrl     = `CFG_ADDR_CTRL
    } cfg_reg_e;

endpackage

`default_nettype wire

/* src/fetch_state_pkg.sv */
`default_nettype none

package fetch_state_pkg;

    // fetch stage occupancy, one-hot
    typedef enum logic [3:0] {
        // stale read in flight after a flush
        state_leap  = 4'b0001,
        // idle, or item waiting on its read
        state_empty = 4'b0010,
        // last word went straight to decode
        state_pipe  = 4'b0100,
        // word held in the buffer
        state_full  = 4'b1000
    } fetch_state_e;

endpackage

`default_nettype wire

/* include/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// datapath widths
`define BUS_WIDTH       32
`define DATA_WIDTH      32

// boot pc and trap vector out of reset
`define RESET_PC        32'h0000_1000
`define RESET_TRAP_VEC  32'h0000_0100

// loaded into the instruction buffer when killed
`define INST_NOP        32'h0000_0013

// config register port
`define CFG_ADDR_W        2
`define CFG_ADDR_BOOT_PC  2'd0
`define CFG_ADDR_TRAP_VEC 2'd1
`define CFG_ADDR_CTRL     2'd2
`define CFG_CTRL_EN_BIT   0

`endif
